/* source/mem_access_pkg.sv */
// Shared widths, depths and derived counter sizes
// Request, response and Avalon command structs

package mem_access_pkg;

    // Avalon and data path widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 128;
    localparam int BE_W   = 16;
    localparam int TAG_W  = 4;

    // Queue and in-flight limits
    localparam int REQ_DEPTH       = 4;
    localparam int MAX_RD_INFLIGHT = 4;
    localparam int RSP_CREDIT_MAX  = 8;

    // Pointer and counter widths derived from the depths above
    localparam int REQ_PTR_W = $clog2(REQ_DEPTH);
    localparam int REQ_CNT_W = $clog2(REQ_DEPTH + 1);
    localparam int RD_PTR_W  = $clog2(MAX_RD_INFLIGHT);
    localparam int RD_CNT_W  = $clog2(MAX_RD_INFLIGHT + 1);
    localparam int RSP_CNT_W = $clog2(RSP_CREDIT_MAX + 1);

    // Request kind
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } mem_op_t;

    // Client request, one beat
    typedef struct packed {
        mem_op_t             op;
        logic [TAG_W-1:0]    tag;
        logic [ADDR_W-1:0]   addr;
        logic [BE_W-1:0]     be;
        logic [DATA_W-1:0]   wdata;
    } mem_req_t;

    // Client response, data is zero for write acks
    typedef struct packed {
        mem_op_t             op;
        logic [TAG_W-1:0]    tag;
        logic [DATA_W-1:0]   data;
    } mem_rsp_t;

    // Avalon-MM master command fields
    typedef struct packed {
        logic                read;
        logic                write;
        logic [ADDR_W-1:0]   address;
        logic [DATA_W-1:0]   writedata;
        logic [BE_W-1:0]     byteenable;
    } avm_cmd_t;

endpackage

/* source/request_queue.sv */
// Credit-controlled request FIFO
// Returns one client credit per popped entry

`timescale 1ns/100ps

module request_queue (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  mem_access_pkg::mem_req_t req,
    input  logic                     pop,
    output mem_access_pkg::mem_req_t head,
    output logic                     head_valid,
    output logic                     req_credit
);

    import mem_access_pkg::*;

    // Entry storage for request payloads
    mem_req_t mem [REQ_DEPTH];

    // Circular pointers and occupancy
    logic [REQ_PTR_W-1:0] wr_ptr;
    logic [REQ_PTR_W-1:0] rd_ptr;
    logic [REQ_CNT_W-1:0] count;

    logic push;
    logic do_pop;

    // Client pushes only while holding a credit
    assign push   = req_valid;
    // Guard against a stray pop on an empty queue
    assign do_pop = pop && head_valid;

    // Write side
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

    // Pointers, occupancy and registered credit return
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count unchanged
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back in the cycle after each pop
            req_credit <= do_pop;
        end
    end

    // Head is read straight from storage
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // A push into a full queue means the client overspent its credits
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (reset)
        req_valid |-> (count != REQ_CNT_W'(REQ_DEPTH))
    ) else $error("request_queue: push while full");

endmodule

/* source/avalon_master_ctrl.sv */
// Control FSM for Avalon-MM read and write commands
// Holds each command until waitrequest drops

`timescale 1ns/100ps

module avalon_master_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  mem_access_pkg::mem_req_t    head,
    input  logic                        head_valid,
    output logic                        pop,
    input  logic                        rsp_slot_avail,
    input  logic                        rd_slot_avail,
    input  logic                        rd_idle,
    output logic                        issue_rd,
    output logic                        issue_wr,
    output logic [mem_access_pkg::TAG_W-1:0] issue_tag,
    output mem_access_pkg::avm_cmd_t    avm,
    input  logic                        avm_waitrequest
);

    import mem_access_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RD_CMD,
        ST_WR_CMD
    } state_t;

    state_t   state_q;
    state_t   state_d;

    // Latched copy of the head request
    mem_req_t cmd_q;
    logic     load;

    // Gating for each request kind
    logic     can_rd;
    logic     can_wr;

    // Read needs a response credit and a free in-flight slot
    assign can_rd = head_valid && (head.op == OP_READ)
                    && rsp_slot_avail && rd_slot_avail;
    // Write needs a response credit and no reads outstanding
    assign can_wr = head_valid && (head.op == OP_WRITE)
                    && rsp_slot_avail && rd_idle;

    // State register
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Command register
    always_ff @(posedge clk) begin
        if (load) begin
            cmd_q <= head;
        end
    end

    // Next state, pop and issue strobes
    always_comb begin
        state_d  = state_q;
        load     = 1'b0;
        pop      = 1'b0;
        issue_rd = 1'b0;
        issue_wr = 1'b0;

        case (state_q)
            ST_IDLE: begin
                // Latch head for a command on the next cycle
                if (can_rd) begin
                    load    = 1'b1;
                    state_d = ST_RD_CMD;
                end else if (can_wr) begin
                    load    = 1'b1;
                    state_d = ST_WR_CMD;
                end
            end

            ST_RD_CMD: begin
                // Accepted on first cycle with waitrequest low
                if (!avm_waitrequest) begin
                    pop      = 1'b1;
                    issue_rd = 1'b1;
                    state_d  = ST_IDLE;
                end
            end

            ST_WR_CMD: begin
                if (!avm_waitrequest) begin
                    pop      = 1'b1;
                    issue_wr = 1'b1;
                    state_d  = ST_IDLE;
                end
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // Tag of the command being accepted
    assign issue_tag = cmd_q.tag;

    // Avalon fields from the command register and zero in idle
    always_comb begin
        avm = '0;
        case (state_q)
            ST_RD_CMD: begin
                avm.read       = 1'b1;
                avm.address    = cmd_q.addr;
                avm.byteenable = cmd_q.be;
            end
            ST_WR_CMD: begin
                avm.write      = 1'b1;
                avm.address    = cmd_q.addr;
                avm.writedata  = cmd_q.wdata;
                avm.byteenable = cmd_q.be;
            end
            default: begin
                avm = '0;
            end
        endcase
    end

    // Slave sees a stable command for as long as it stalls
    a_cmd_stable: assert property (
        @(posedge clk) disable iff (reset)
        (avm.read || avm.write) && avm_waitrequest |=> $stable(avm)
    ) else $error("avalon_master_ctrl: command changed under waitrequest");

endmodule

/* source/read_return.sv */
// In-flight read tag FIFO and response credit counter
// Registered response output for read data and write acks

`timescale 1ns/100ps

module read_return (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             rsp_credit,
    input  logic                             issue_rd,
    input  logic                             issue_wr,
    input  logic [mem_access_pkg::TAG_W-1:0] issue_tag,
    input  logic                             avm_readdatavalid,
    input  logic [mem_access_pkg::DATA_W-1:0] avm_readdata,
    output logic                             rsp_slot_avail,
    output logic                             rd_slot_avail,
    output logic                             rd_idle,
    output logic                             rsp_valid,
    output mem_access_pkg::mem_rsp_t         rsp
);

    import mem_access_pkg::*;

    // Tags of outstanding reads, oldest at rd_ptr
    logic [TAG_W-1:0]     tag_mem [MAX_RD_INFLIGHT];
    logic [RD_PTR_W-1:0]  wr_ptr;
    logic [RD_PTR_W-1:0]  rd_ptr;
    logic [RD_CNT_W-1:0]  rd_count;

    // Response slots granted by the client and not yet spent
    logic [RSP_CNT_W-1:0] credit_cnt;
    logic                 spend;

    assign spend = issue_rd || issue_wr;

    always_ff @(posedge clk) begin
        if (issue_rd) begin
            tag_mem[wr_ptr] <= issue_tag;
        end
        // Response payload, read data wins if both ever coincide
        if (avm_readdatavalid) begin
            rsp <= '{op: OP_READ, tag: tag_mem[rd_ptr], data: avm_readdata};
        end else if (issue_wr) begin
            rsp <= '{op: OP_WRITE, tag: issue_tag, data: '0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            rd_count   <= '0;
            credit_cnt <= '0;
            rsp_valid  <= 1'b0;
        end else begin
            wr_ptr     <= wr_ptr + RD_PTR_W'(issue_rd);
            rd_ptr     <= rd_ptr + RD_PTR_W'(avm_readdatavalid);
            rd_count   <= rd_count + RD_CNT_W'(issue_rd) - RD_CNT_W'(avm_readdatavalid);
            credit_cnt <= credit_cnt + RSP_CNT_W'(rsp_credit) - RSP_CNT_W'(spend);
            rsp_valid  <= avm_readdatavalid || issue_wr;
        end
    end

    assign rsp_slot_avail = (credit_cnt != '0);
    assign rd_slot_avail  = (rd_count != RD_CNT_W'(MAX_RD_INFLIGHT));
    assign rd_idle        = (rd_count == '0);

    // Read data with no read outstanding on the bus
    a_rdv_inflight: assert property (
        @(posedge clk) disable iff (reset)
        avm_readdatavalid |-> !rd_idle
    ) else $error("read_return: readdatavalid with no read in flight");

    // Credit counter stays within 0..RSP_CREDIT_MAX
    a_credit_range: assert property (
        @(posedge clk) disable iff (reset)
        !(spend && !rsp_credit && credit_cnt == '0) &&
        !(rsp_credit && !spend && credit_cnt == RSP_CNT_W'(RSP_CREDIT_MAX))
    ) else $error("read_return: response credit overflow or underflow");

endmodule

/* source/mem_access_top.sv */
// DDR3 access block top level
// Request queue, Avalon control FSM and response return path

`timescale 1ns/100ps

module mem_access_top (
    input  logic                              clk,
    input  logic                              reset,
    // Client requests
    input  logic                              req_valid,
    input  mem_access_pkg::mem_req_t          req,
    output logic                              req_credit,
    // Client responses
    input  logic                              rsp_credit,
    output logic                              rsp_valid,
    output mem_access_pkg::mem_rsp_t          rsp,
    // Avalon-MM master to the memory controller
    output mem_access_pkg::avm_cmd_t          avm,
    input  logic                              avm_waitrequest,
    input  logic                              avm_readdatavalid,
    input  logic [mem_access_pkg::DATA_W-1:0] avm_readdata
);

    import mem_access_pkg::*;

    // Queue head to controller
    mem_req_t         head;
    logic             head_valid;
    logic             pop;

    // Controller and return path handshake
    logic             rsp_slot_avail;
    logic             rd_slot_avail;
    logic             rd_idle;
    logic             issue_rd;
    logic             issue_wr;
    logic [TAG_W-1:0] issue_tag;

    request_queue i_request_queue (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .pop        (pop),
        .head       (head),
        .head_valid (head_valid),
        .req_credit (req_credit)
    );

    avalon_master_ctrl i_avalon_master_ctrl (
        .clk             (clk),
        .reset           (reset),
        .head            (head),
        .head_valid      (head_valid),
        .pop             (pop),
        .rsp_slot_avail  (rsp_slot_avail),
        .rd_slot_avail   (rd_slot_avail),
        .rd_idle         (rd_idle),
        .issue_rd        (issue_rd),
        .issue_wr        (issue_wr),
        .issue_tag       (issue_tag),
        .avm             (avm),
        .avm_waitrequest (avm_waitrequest)
    );

    read_return i_read_return (
        .clk               (clk),
        .reset             (reset),
        .rsp_credit        (rsp_credit),
        .issue_rd          (issue_rd),
        .issue_wr          (issue_wr),
        .issue_tag         (issue_tag),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata      (avm_readdata),
        .rsp_slot_avail    (rsp_slot_avail),
        .rd_slot_avail     (rd_slot_avail),
        .rd_idle           (rd_idle),
        .rsp_valid         (rsp_valid),
        .rsp               (rsp)
    );

endmodule

/* dv/avalon_mem_model.sv */
// Avalon-MM slave memory model for the DDR3 access block testbench
// One stall cycle per command, reads return in order three cycles after acceptance

`timescale 1ns/100ps

module avalon_mem_model (
    input  logic                              clk,
    input  logic                              reset,
    input  mem_access_pkg::avm_cmd_t          avm,
    output logic                              avm_waitrequest,
    output logic                              avm_readdatavalid,
    output logic [mem_access_pkg::DATA_W-1:0] avm_readdata
);

    import mem_access_pkg::*;

    // 64 words of 16 bytes, word index from address bits 9:4
    logic [DATA_W-1:0] mem [64];
    logic [5:0]        idx;

    // Set once a command has been stalled for its first cycle
    logic              stalled;
    logic              cmd_seen;
    logic              accept;

    // Three-stage read return pipeline
    logic [2:0]        vld_pipe;
    logic [DATA_W-1:0] data_pipe [3];

    // Fill pattern, every lane carries the word index
    function automatic logic [DATA_W-1:0] init_pattern(int word);
        logic [31:0] k;
        k = 32'(word);
        return {32'hA1A10000 | k, 32'hB2B20000 | (k << 8),
                32'hC3C30000 | k, 32'hD4D40000 | (k << 8)};
    endfunction

    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = init_pattern(i);
        end
    end

    assign idx      = avm.address[9:4];
    assign cmd_seen = avm.read || avm.write;

    // Stall on the first cycle of every command
    assign avm_waitrequest = cmd_seen && !stalled;
    assign accept          = cmd_seen && !avm_waitrequest;

    always @(posedge clk) begin
        if (reset) begin
            stalled  <= 1'b0;
            vld_pipe <= '0;
        end else begin
            stalled  <= cmd_seen && avm_waitrequest;
            vld_pipe <= {vld_pipe[1:0], accept && avm.read};
        end
        // Read data captured at acceptance and shifted along
        data_pipe[0] <= mem[idx];
        data_pipe[1] <= data_pipe[0];
        data_pipe[2] <= data_pipe[1];
        // Byte enables select which lanes a write touches
        if (accept && avm.write) begin
            for (int b = 0; b < BE_W; b++) begin
                if (avm.byteenable[b]) begin
                    mem[idx][b*8 +: 8] <= avm.writedata[b*8 +: 8];
                end
            end
        end
    end

    assign avm_readdatavalid = vld_pipe[2];
    assign avm_readdata      = data_pipe[2];

endmodule

/* dv/tb_mem_access.sv */
// Directed testbench for the DDR3 access block
// Clock, reset, LCG, reference memory, compare tasks and the five test tasks

`timescale 1ns/100ps

module tb_mem_access;

    import mem_access_pkg::*;

    // Five tests take a few hundred cycles and 4000 leaves ample margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic              clk;
    logic              reset;
    logic              req_valid;
    mem_req_t          req;
    logic              req_credit;
    logic              rsp_credit;
    logic              rsp_valid;
    mem_rsp_t          rsp;
    avm_cmd_t          avm;
    logic              avm_waitrequest;
    logic              avm_readdatavalid;
    logic [DATA_W-1:0] avm_readdata;

    // Stimulus state and reference model
    logic [31:0]       lcg_state;
    logic [TAG_W-1:0]  next_tag;
    logic [DATA_W-1:0] ref_mem [64];
    mem_rsp_t          exp_q [$];
    mem_rsp_t          rsp_q [$];
    avm_cmd_t          cmd_exp_q [$];

    // Credits held by the client side and observed event counts
    int                req_credits;
    int                rsp_credits;
    int                cycle_count;
    int                rsp_count;
    int                credit_pulses;
    int                cmd_cycles;

    mem_access_top i_mem_access_top (
        .clk               (clk),
        .reset             (reset),
        .req_valid         (req_valid),
        .req               (req),
        .req_credit        (req_credit),
        .rsp_credit        (rsp_credit),
        .rsp_valid         (rsp_valid),
        .rsp               (rsp),
        .avm               (avm),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata      (avm_readdata)
    );

    avalon_mem_model i_avalon_mem_model (
        .clk               (clk),
        .reset             (reset),
        .avm               (avm),
        .avm_waitrequest   (avm_waitrequest),
        .avm_readdatavalid (avm_readdatavalid),
        .avm_readdata      (avm_readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Output monitor sampling DUT outputs on the rising edge
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (!reset) begin
            if (rsp_valid) begin
                rsp_q.push_back(rsp);
                rsp_count = rsp_count + 1;
                // Each response spends one credit granted by the client
                if (rsp_credits == 0) begin
                    $display("Response sent while no response credit was held");
                    $display("Some tests failed");
                    $fatal(1, "response without credit");
                end else begin
                    rsp_credits = rsp_credits - 1;
                end
            end
            if (req_credit) begin
                req_credits   = req_credits + 1;
                credit_pulses = credit_pulses + 1;
            end
            if (avm.read || avm.write) begin
                cmd_cycles = cmd_cycles + 1;
                // Accepted command against the oldest request sent
                if (!avm_waitrequest) begin
                    if (cmd_exp_q.size() == 0) begin
                        $display("Avalon command accepted with no request outstanding");
                        $display("Some tests failed");
                        $fatal(1, "unexpected command");
                    end else begin
                        compare_cmd(avm, cmd_exp_q.pop_front(), "accepted Avalon command");
                    end
                end
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run exceeded %0d cycles waiting on the DUT", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [DATA_W-1:0] random_word();
        logic [DATA_W-1:0] w;
        for (int i = 0; i < DATA_W / 32; i++) begin
            w[i*32 +: 32] = next_random();
        end
        return w;
    endfunction

    // Word aligned address with random upper bits
    function automatic logic [ADDR_W-1:0] random_addr();
        logic [31:0] r;
        r = next_random();
        return {r[31:4], 4'h0};
    endfunction

    // Reference starts with the same fill as the slave model
    function automatic logic [DATA_W-1:0] init_pattern(int word);
        logic [31:0] k;
        k = 32'(word);
        return {32'hA1A10000 | k, 32'hB2B20000 | (k << 8),
                32'hC3C30000 | k, 32'hD4D40000 | (k << 8)};
    endfunction

    // New bytes where the mask is set, old bytes elsewhere
    function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old_word,
                                                      logic [DATA_W-1:0] new_word,
                                                      logic [BE_W-1:0] be);
        logic [DATA_W-1:0] w;
        w = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                w[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return w;
    endfunction

    task automatic compare_rsp(input mem_rsp_t got, input mem_rsp_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got op %0d tag %0d data %h", $time, what,
                     got.op, got.tag, got.data);
            $display("MISMATCH at %0t: %s, expected op %0d tag %0d data %h", $time, what,
                     exp.op, exp.tag, exp.data);
            $display("Some tests failed");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic compare_cmd(input avm_cmd_t got, input avm_cmd_t exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got rd %0b wr %0b addr %h be %h data %h", $time,
                     what, got.read, got.write, got.address, got.byteenable, got.writedata);
            $display("MISMATCH at %0t: %s, expected rd %0b wr %0b addr %h be %h data %h",
                     $time, what, exp.read, exp.write, exp.address, exp.byteenable,
                     exp.writedata);
            $display("Some tests failed");
            $fatal(1, "command mismatch");
        end
    endtask

    task automatic compare_credits(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s, got %0d credits, expected %0d", $time, what,
                     got, exp);
            $display("Some tests failed");
            $fatal(1, "credit mismatch");
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
            $display("Some tests failed");
            $fatal(1, "event count mismatch");
        end
    endtask

    // One request beat after waiting for a request credit
    task automatic send_req(input mem_op_t op, input logic [ADDR_W-1:0] addr,
                            input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
                            output logic [TAG_W-1:0] tag);
        avm_cmd_t cmd;
        while (req_credits == 0) begin
            @(negedge clk);
        end
        // Expected bus command with zero writedata on reads
        cmd            = '0;
        cmd.read       = (op == OP_READ);
        cmd.write      = (op == OP_WRITE);
        cmd.address    = addr;
        cmd.byteenable = be;
        if (op == OP_WRITE) begin
            cmd.writedata = wdata;
        end
        cmd_exp_q.push_back(cmd);
        tag         = next_tag;
        next_tag    = next_tag + 1'b1;
        req         = '{op: op, tag: tag, addr: addr, be: be, wdata: wdata};
        req_valid   = 1'b1;
        req_credits = req_credits - 1;
        @(negedge clk);
        req_valid   = 1'b0;
    endtask

    // Requests complete in order and the reference updates at send time
    task automatic issue_write(input logic [ADDR_W-1:0] addr, input logic [BE_W-1:0] be,
                               input logic [DATA_W-1:0] wdata);
        logic [TAG_W-1:0] tag;
        send_req(OP_WRITE, addr, be, wdata, tag);
        ref_mem[addr[9:4]] = merge_bytes(ref_mem[addr[9:4]], wdata, be);
        exp_q.push_back('{op: OP_WRITE, tag: tag, data: '0});
    endtask

    task automatic issue_read(input logic [ADDR_W-1:0] addr);
        logic [TAG_W-1:0] tag;
        send_req(OP_READ, addr, '1, '0, tag);
        exp_q.push_back('{op: OP_READ, tag: tag, data: ref_mem[addr[9:4]]});
    endtask

    // One credit per cycle on rsp_credit
    task automatic grant_rsp_credits(input int n);
        for (int i = 0; i < n; i++) begin
            rsp_credit  = 1'b1;
            rsp_credits = rsp_credits + 1;
            @(negedge clk);
        end
        rsp_credit = 1'b0;
    endtask

    // Next response against the oldest expected one
    task automatic check_next_rsp(input string what);
        mem_rsp_t got;
        mem_rsp_t exp;
        while (rsp_q.size() == 0) begin
            @(negedge clk);
        end
        got = rsp_q.pop_front();
        exp = exp_q.pop_front();
        compare_rsp(got, exp, what);
    endtask

    task automatic test_reset_state();
        repeat (20) @(negedge clk);
        compare_count(rsp_count, 0, "rsp_valid after reset");
        compare_count(credit_pulses, 0, "req_credit after reset");
        compare_count(cmd_cycles, 0, "avm command after reset");
        compare_credits(req_credits, REQ_DEPTH, "request credits after reset");
    endtask

    task automatic test_write_read();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        addr = random_addr();
        data = random_word();
        grant_rsp_credits(2);
        issue_write(addr, '1, data);
        issue_read(addr);
        check_next_rsp("full-mask write ack");
        check_next_rsp("read after full-mask write");
    endtask

    task automatic test_byte_enables();
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [31:0]       r;
        logic [BE_W-1:0]   be;
        addr = random_addr();
        data = random_word();
        r    = next_random();
        be   = r[15:0];
        // Keep the mask truly partial
        if (be == '1 || be == '0) begin
            be = 16'h0FF0;
        end
        grant_rsp_credits(2);
        issue_write(addr, be, data);
        issue_read(addr);
        check_next_rsp("partial-mask write ack");
        check_next_rsp("read after partial-mask write");
    endtask

    task automatic test_pipelined_reads();
        grant_rsp_credits(4);
        for (int i = 0; i < 4; i++) begin
            issue_read(random_addr());
        end
        for (int i = 0; i < 4; i++) begin
            check_next_rsp("pipelined read");
        end
        // Last credit return trails its pop by one cycle
        repeat (2) @(negedge clk);
        compare_credits(req_credits, REQ_DEPTH, "request credits after pipelined reads");
    endtask

    task automatic test_credit_backpressure();
        int base;
        base = rsp_count;
        for (int i = 0; i < 3; i++) begin
            issue_read(random_addr());
        end
        repeat (30) @(negedge clk);
        compare_count(rsp_count - base, 0, "responses with no response credit");
        for (int i = 0; i < 3; i++) begin
            base = rsp_count;
            grant_rsp_credits(1);
            check_next_rsp("read under response back-pressure");
            repeat (10) @(negedge clk);
            compare_count(rsp_count - base, 1, "responses for one granted credit");
        end
    endtask

    initial begin
        reset         = 1'b1;
        req_valid     = 1'b0;
        req           = '0;
        rsp_credit    = 1'b0;
        lcg_state     = 32'd4988;
        next_tag      = '0;
        req_credits   = 0;
        rsp_credits   = 0;
        cycle_count   = 0;
        rsp_count     = 0;
        credit_pulses = 0;
        cmd_cycles    = 0;
        for (int i = 0; i < 64; i++) begin
            ref_mem[i] = init_pattern(i);
        end

        // Reset held over five rising edges and released on a falling edge
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset       = 1'b0;
        req_credits = REQ_DEPTH;

        test_reset_state();
        test_write_read();
        test_byte_enables();
        test_pipelined_reads();
        test_credit_backpressure();

        compare_count(rsp_q.size(), 0, "responses left unchecked");
        compare_count(cmd_exp_q.size(), 0, "Avalon commands never accepted");
        compare_credits(req_credits, REQ_DEPTH, "request credits at end of run");
        $display("All tests passed");
        $finish;
    end

endmodule

/* tb.f */
source/mem_access_pkg.sv
source/request_queue.sv
source/avalon_master_ctrl.sv
source/read_return.sv
source/mem_access_top.sv
dv/avalon_mem_model.sv
dv/tb_mem_access.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DDR3 access block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mem_access \
    -Mdir obj_dir \
    -f tb.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vtb_mem_access 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

# Pass only if the testbench printed its pass line
if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi
